// File: verilog/lspcPkg.sv
`default_nettype none

package lspcPkg;

	// Register offsets on M68K_ADDR[2:1]
	// Bit 3 is not decoded, so the bank shows up twice
	localparam logic [1:0] regVramAddr = 2'd0;	// $3C0000 / $3C0008
	localparam logic [1:0] regVramRw = 2'd1;	// $3C0002 / $3C000A
	localparam logic [1:0] regVramMod = 2'd2;	// $3C0004 / $3C000C
	localparam logic [1:0] regLspcMode = 2'd3;	// $3C0006 / $3C000E

	// Slow VRAM, 32K words
	typedef logic [14:0] slowAddrT;

	// Fast VRAM, 2K words
	typedef logic [10:0] fastAddrT;

	// One VRAM or bus word
	typedef logic [15:0] vramWordT;

	// CLK_24M cycles between CPU access slots
	localparam int slowSlotDefault = 4;	// 6MHz
	localparam int fastSlotDefault = 2;	// 12MHz

endpackage

`default_nettype wire

// File: verilog/cpuRegDecode.sv
`timescale 1ns/1ps
`default_nettype none

module cpuRegDecode (
	input logic CLK_24M,
	input logic RESETP,
	input logic [3:1] M68K_ADDR,
	input logic nLSPWE,
	input lspcPkg::vramWordT M68K_DATA,
	input logic writeDone,
	output lspcPkg::slowAddrT slowAddr,
	output lspcPkg::fastAddrT fastAddr,
	output logic zone,
	output lspcPkg::vramWordT writeData,
	output logic writeReqSlow,
	output logic writeReqFast,
	output logic reloadSlow,
	output logic reloadFast,
	output lspcPkg::vramWordT regVramMod,
	output lspcPkg::vramWordT regLspcMode
);

	logic nLspweQ;	// Strobe level one clock back
	logic wrRise;	// End of a CPU write cycle
	logic reqPending;
	lspcPkg::vramWordT vramAddr;	// VRAMADDR, bit 15 is the zone
	lspcPkg::vramWordT steppedAddr;

	// Data and offset are still valid when the strobe goes back up
	assign wrRise = nLSPWE & ~nLspweQ;
	assign reqPending = writeReqSlow | writeReqFast;

	assign zone = vramAddr[15];
	assign slowAddr = vramAddr[14:0];
	assign fastAddr = vramAddr[10:0];

	// Auto-increment wraps inside the zone
	always_comb
	begin
		steppedAddr = vramAddr;
		if (zone)
			steppedAddr[10:0] = vramAddr[10:0] + regVramMod[10:0];	// Bits 15:11 kept
		else
			steppedAddr[14:0] = vramAddr[14:0] + regVramMod[14:0];	// Bit 15 stays 0
	end

	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
		begin
			nLspweQ <= 1'b1;	// Bus idle
			vramAddr <= '0;
			writeData <= '0;
			regVramMod <= '0;
			regLspcMode <= '0;
			writeReqSlow <= 1'b0;
			writeReqFast <= 1'b0;
			reloadSlow <= 1'b0;
			reloadFast <= 1'b0;
		end
		else
		begin
			nLspweQ <= nLSPWE;
			reloadSlow <= 1'b0;	// Strobes last one cycle
			reloadFast <= 1'b0;

			// Write slot done, step and refetch
			if (writeDone)
			begin
				writeReqSlow <= 1'b0;
				writeReqFast <= 1'b0;
				vramAddr <= steppedAddr;
				reloadSlow <= ~zone;
				reloadFast <= zone;
			end

			if (wrRise)
			begin
				case (M68K_ADDR[2:1])
					lspcPkg::regVramAddr:
					begin
						vramAddr <= M68K_DATA;
						reloadSlow <= ~M68K_DATA[15];	// Refetch from the new zone
						reloadFast <= M68K_DATA[15];
					end
					lspcPkg::regVramRw:
					begin
						// Dropped if the previous write is still waiting
						if (~reqPending)
						begin
							writeData <= M68K_DATA;
							writeReqSlow <= ~zone;
							writeReqFast <= zone;
						end
					end
					lspcPkg::regVramMod:
						regVramMod <= M68K_DATA;
					default:
						regLspcMode <= M68K_DATA;	// LSPCMODE
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/vramCycle.sv
`timescale 1ns/1ps
`default_nettype none

module vramCycle #(
	parameter type addrT = lspcPkg::slowAddrT,
	parameter int slotPeriod = lspcPkg::slowSlotDefault
) (
	input logic CLK_24M,
	input logic RESETP,
	input addrT addr,
	input lspcPkg::vramWordT writeData,
	input logic writeReq,
	input logic reload,
	output logic ack,
	output lspcPkg::vramWordT rdData,
	output logic rdValid
);

	// RAM size follows the zone address width
	localparam int depth = 1 << $bits(addrT);
	localparam int cntW = (slotPeriod > 1) ? $clog2(slotPeriod) : 1;
	localparam logic [cntW-1:0] lastCnt = cntW'(slotPeriod - 1);

	lspcPkg::vramWordT mem [0:depth-1];
	logic [cntW-1:0] slotCnt;	// Free running slot timer
	logic slot;					// CPU access slot this cycle
	logic reloadPend;			// Reload waiting for a slot
	logic reloadNow;
	logic doWrite;

	assign slot = (slotCnt == lastCnt);
	assign reloadNow = reloadPend | reload;	// Strobe can use the slot it lands in
	assign doWrite = slot & writeReq & ~ack;	// Write has priority, once per request

	// Slot timer, no video fetches to share with here
	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
			slotCnt <= '0;
		else if (slot)
			slotCnt <= '0;
		else
			slotCnt <= slotCnt + 1'b1;
	end

	// Control side
	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
		begin
			ack <= 1'b0;
			rdValid <= 1'b0;
			reloadPend <= 1'b0;
		end
		else
		begin
			rdValid <= 1'b0;
			if (doWrite)
			begin
				ack <= 1'b1;
				reloadPend <= reloadNow;	// Read waits for the next slot
			end
			else if (slot & reloadNow)
			begin
				rdValid <= 1'b1;
				reloadPend <= 1'b0;
			end
			else
				reloadPend <= reloadNow;

			// Ack follows the request back down
			if (~writeReq)
				ack <= 1'b0;
		end
	end

	// Array port, write or read per slot
	always_ff @(posedge CLK_24M)
	begin
		if (doWrite)
			mem[addr] <= writeData;
		else if (slot & reloadNow)
			rdData <= mem[addr];
	end

endmodule

`default_nettype wire

// File: verilog/cpuReadPort.sv
`timescale 1ns/1ps
`default_nettype none

module cpuReadPort (
	input logic CLK_24M,
	input logic RESETP,
	input logic ackSlow,
	input logic ackFast,
	input logic rdValidSlow,
	input logic rdValidFast,
	input lspcPkg::vramWordT rdDataSlow,
	input lspcPkg::vramWordT rdDataFast,
	input lspcPkg::vramWordT regVramMod,
	input lspcPkg::vramWordT regLspcMode,
	input logic [3:1] M68K_ADDR,
	input logic nLSPOE,
	input logic nLSPWE,
	output logic writeDone,
	inout wire lspcPkg::vramWordT M68K_DATA
);

	logic ackAny;
	logic ackPrev;
	logic busEn;
	lspcPkg::vramWordT readBuf;	// Last word fetched from either zone
	lspcPkg::vramWordT busOut;

	// Only one zone acks per request
	assign ackAny = ackSlow | ackFast;
	assign writeDone = ackAny & ~ackPrev;	// Rising edge only

	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
			ackPrev <= 1'b0;
		else
			ackPrev <= ackAny;
	end

	// Buffer takes whichever engine just fetched
	always_ff @(posedge CLK_24M or posedge RESETP)
	begin
		if (RESETP)
			readBuf <= '0;
		else if (rdValidSlow)
			readBuf <= rdDataSlow;
		else if (rdValidFast)
			readBuf <= rdDataFast;
	end

	// Read mux, bit 3 ignored
	always_comb
	begin
		case (M68K_ADDR[2:1])
			lspcPkg::regVramAddr,
			lspcPkg::regVramRw:
				busOut = readBuf;	// Both offsets give the buffer
			lspcPkg::regVramMod:
				busOut = regVramMod;
			default:
				busOut = regLspcMode;
		endcase
	end

	// Never drive while the CPU writes
	assign busEn = ~nLSPOE & nLSPWE;
	assign M68K_DATA = busEn ? busOut : 'z;

endmodule

`default_nettype wire

// File: verilog/lspcVramTop.sv
`timescale 1ns/1ps
`default_nettype none

module lspcVramTop #(
	parameter int slowSlot = lspcPkg::slowSlotDefault,
	parameter int fastSlot = lspcPkg::fastSlotDefault
) (
	input logic CLK_24M,
	input logic RESETP,
	input logic [3:1] M68K_ADDR,
	inout wire lspcPkg::vramWordT M68K_DATA,
	input logic nLSPOE,
	input logic nLSPWE
);

	lspcPkg::slowAddrT slowAddr;
	lspcPkg::fastAddrT fastAddr;
	lspcPkg::vramWordT writeData;
	lspcPkg::vramWordT regVramMod;
	lspcPkg::vramWordT regLspcMode;
	lspcPkg::vramWordT rdDataSlow;
	lspcPkg::vramWordT rdDataFast;
	logic writeReqSlow, writeReqFast;
	logic reloadSlow, reloadFast;
	logic ackSlow, ackFast;
	logic rdValidSlow, rdValidFast;
	logic writeDone;

	cpuRegDecode dec (
		.CLK_24M(CLK_24M), .RESETP(RESETP),
		.M68K_ADDR(M68K_ADDR), .nLSPWE(nLSPWE), .M68K_DATA(M68K_DATA),
		.writeDone(writeDone),
		.slowAddr(slowAddr), .fastAddr(fastAddr), .zone(),
		.writeData(writeData),
		.writeReqSlow(writeReqSlow), .writeReqFast(writeReqFast),
		.reloadSlow(reloadSlow), .reloadFast(reloadFast),
		.regVramMod(regVramMod), .regLspcMode(regLspcMode)
	);

	// Slow VRAM, 32K words
	vramCycle #(.addrT(lspcPkg::slowAddrT), .slotPeriod(slowSlot)) scy (
		.CLK_24M(CLK_24M), .RESETP(RESETP),
		.addr(slowAddr), .writeData(writeData),
		.writeReq(writeReqSlow), .reload(reloadSlow),
		.ack(ackSlow), .rdData(rdDataSlow), .rdValid(rdValidSlow)
	);

	// Fast VRAM, 2K words
	vramCycle #(.addrT(lspcPkg::fastAddrT), .slotPeriod(fastSlot)) fcy (
		.CLK_24M(CLK_24M), .RESETP(RESETP),
		.addr(fastAddr), .writeData(writeData),
		.writeReq(writeReqFast), .reload(reloadFast),
		.ack(ackFast), .rdData(rdDataFast), .rdValid(rdValidFast)
	);

	cpuReadPort rdp (
		.CLK_24M(CLK_24M), .RESETP(RESETP),
		.ackSlow(ackSlow), .ackFast(ackFast),
		.rdValidSlow(rdValidSlow), .rdValidFast(rdValidFast),
		.rdDataSlow(rdDataSlow), .rdDataFast(rdDataFast),
		.regVramMod(regVramMod), .regLspcMode(regLspcMode),
		.M68K_ADDR(M68K_ADDR), .nLSPOE(nLSPOE), .nLSPWE(nLSPWE),
		.writeDone(writeDone), .M68K_DATA(M68K_DATA)
	);

endmodule

`default_nettype wire

// File: tests/vramBus_chk.sv
`timescale 1ns/1ps
`default_nettype none

module vramBus_chk (
	input logic CLK_24M,
	input logic RESETP,
	input logic [3:1] M68K_ADDR,
	input logic nLSPWE,
	input logic busEn,
	input logic writeReqSlow,
	input logic writeReqFast,
	input logic writeDone
);

	// No contention with a CPU write
	busQuiet: assert property (@(posedge CLK_24M) disable iff (RESETP) !nLSPWE |-> !busEn)
		else $error("LSPC drives the data bus while nLSPWE is low");

	// Nothing pending out of reset
	resetIdle: assert property (@(posedge CLK_24M) RESETP |-> !(writeReqSlow || writeReqFast))
		else $error("write request high during reset");

	doneOneCycle: assert property (@(posedge CLK_24M) disable iff (RESETP)
		writeDone |=> !writeDone)
		else $error("writeDone longer than one cycle");

	// VRAMRW write would be dropped
	noOverrun: assert property (@(posedge CLK_24M) disable iff (RESETP)
		($rose(nLSPWE) && M68K_ADDR[2:1] == lspcPkg::regVramRw)
		|-> !(writeReqSlow || writeReqFast))
		else $error("VRAMRW written while a request is pending");

endmodule

`default_nettype wire

// File: tests/lspcVramTb.sv
`timescale 1ns/1ps
`default_nettype none

module lspcVramTb;

	localparam int addrTimeout = 8;		// VRAMADDR write to valid buffer
	localparam int writeTimeout = 16;	// VRAMRW write to stepped and reloaded

	logic CLK_24M = 1'b0;
	logic RESETP;
	logic [3:1] M68K_ADDR;
	logic nLSPOE;
	logic nLSPWE;
	logic tbDrive;				// CPU side owns the bus
	lspcPkg::vramWordT tbData;
	wire lspcPkg::vramWordT M68K_DATA;

	lspcPkg::vramWordT slowRef [0:32767];	// Model of slow VRAM
	lspcPkg::vramWordT fastRef [0:2047];	// Model of fast VRAM
	lspcPkg::vramWordT refAddr;
	lspcPkg::vramWordT refMod;

	string nameQ[$];	// Reads waiting for compare
	lspcPkg::vramWordT expQ[$];
	lspcPkg::vramWordT actQ[$];
	int errors = 0;
	int checks = 0;
	int testErrors = 0;
	string testName = "reset";

	assign M68K_DATA = tbDrive ? tbData : 'z;

	always #10 CLK_24M = ~CLK_24M;	// 20ns period

	lspcVramTop #(
		.slowSlot(lspcPkg::slowSlotDefault),
		.fastSlot(lspcPkg::fastSlotDefault)
	) dut0 (
		.CLK_24M(CLK_24M), .RESETP(RESETP), .M68K_ADDR(M68K_ADDR),
		.M68K_DATA(M68K_DATA), .nLSPOE(nLSPOE), .nLSPWE(nLSPWE)
	);

	// Protocol checker inside the top level
	bind lspcVramTop vramBus_chk chk0 (
		.CLK_24M(CLK_24M), .RESETP(RESETP), .M68K_ADDR(M68K_ADDR), .nLSPWE(nLSPWE),
		.busEn(rdp.busEn), .writeReqSlow(writeReqSlow), .writeReqFast(writeReqFast),
		.writeDone(writeDone)
	);

	// Next address, stepped modulo the zone size, zone bit untouched
	function automatic lspcPkg::vramWordT stepRef(input lspcPkg::vramWordT a,
		input lspcPkg::vramWordT m);
		int unsigned size;
		int unsigned off;
		size = a[15] ? 2048 : 32768;
		off = a % size;
		return lspcPkg::vramWordT'((a - off) + ((off + m) % size));
	endfunction

	function automatic lspcPkg::vramWordT refWord(input lspcPkg::vramWordT a);
		return a[15] ? fastRef[a[10:0]] : slowRef[a[14:0]];
	endfunction

	// One CPU write, taken on the nLSPWE rise
	task automatic busWrite(input logic [1:0] offset, input lspcPkg::vramWordT data);
		@(posedge CLK_24M);
		#2;
		M68K_ADDR = {1'b0, offset};
		tbData = data;
		tbDrive = 1'b1;
		nLSPWE = 1'b0;
		@(posedge CLK_24M);
		#2;
		nLSPWE = 1'b1;
		@(posedge CLK_24M);
		#2;
		tbDrive = 1'b0;	// Data held past the edge that sees the rise
	endtask

	// Sampled mid cycle, handed to the compare process
	task automatic busRead(input logic [1:0] offset, input lspcPkg::vramWordT expected);
		@(posedge CLK_24M);
		#2;
		M68K_ADDR = {1'b0, offset};
		nLSPOE = 1'b0;
		@(negedge CLK_24M);
		nameQ.push_back(testName);
		expQ.push_back(expected);
		actQ.push_back(M68K_DATA);
		@(posedge CLK_24M);
		#2;
		nLSPOE = 1'b1;
	endtask

	// Polls writeDone or a reload pulse
	task automatic waitPulse(input bit done, input int limit);
		int n;
		bit seen;
		n = 0;
		seen = 1'b0;
		while (!seen)
		begin
			@(posedge CLK_24M);
			#1;
			seen = done ? dut0.writeDone : (dut0.rdValidSlow | dut0.rdValidFast);
			n++;
			if (!seen && n >= limit)
			begin
				$display("Timeout in %s, no %s within %0d cycles", testName,
					done ? "write completion" : "buffer reload", limit);
				$display("Simulation failed");
				$finish;
			end
		end
	endtask

	task automatic setAddr(input lspcPkg::vramWordT a);
		busWrite(lspcPkg::regVramAddr, a);
		refAddr = a;
		waitPulse(1'b0, addrTimeout);
	endtask

	task automatic setMod(input lspcPkg::vramWordT m);
		busWrite(lspcPkg::regVramMod, m);
		refMod = m;
	endtask

	task automatic vramWrite(input lspcPkg::vramWordT data);
		busWrite(lspcPkg::regVramRw, data);
		if (refAddr[15])
			fastRef[refAddr[10:0]] = data;
		else
			slowRef[refAddr[14:0]] = data;
		waitPulse(1'b1, writeTimeout);	// Stored
		waitPulse(1'b0, writeTimeout);	// Stepped and reloaded
		refAddr = stepRef(refAddr, refMod);
	endtask

	// Re-address and read the word back
	task automatic checkWord(input lspcPkg::vramWordT a);
		setAddr(a);
		busRead(lspcPkg::regVramRw, refWord(a));
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		int n;
		n = 0;
		while (actQ.size() > 0)
		begin
			@(posedge CLK_24M);
			#1;
			n++;
			if (n >= 4)
			begin
				$display("Compare process stalled in %s", testName);
				$display("Simulation failed");
				$finish;
			end
		end
		$display("%s %s", testErrors == 0 ? "[PASS]" : "[ERR] ", testName);
	endtask

	// Compare process, drains the read queue each edge
	always @(posedge CLK_24M)
	begin
		while (actQ.size() > 0)
		begin
			checks++;
			assert (actQ[0] === expQ[0])
			else
			begin
				$display("[FAIL] %s: expected %h, actual %h", nameQ[0], expQ[0], actQ[0]);
				errors++;
				testErrors++;
			end
			void'(nameQ.pop_front());
			void'(expQ.pop_front());
			void'(actQ.pop_front());
		end
	end

	initial
	begin
		lspcPkg::vramWordT a;
		lspcPkg::vramWordT w;
		void'($urandom(32'h3f2bd59a));
		RESETP = 1'b1;
		M68K_ADDR = '0;
		nLSPOE = 1'b1;
		nLSPWE = 1'b1;
		tbDrive = 1'b0;
		tbData = '0;
		refAddr = '0;
		refMod = '0;
		repeat (8) @(posedge CLK_24M);
		#2;
		RESETP = 1'b0;

		startTest("regReadback");
		w = lspcPkg::vramWordT'($urandom);
		setMod(w);
		busWrite(lspcPkg::regLspcMode, ~w);
		busRead(lspcPkg::regVramMod, w);
		busRead(lspcPkg::regLspcMode, ~w);
		endTest();

		startTest("slowSequence");
		a = lspcPkg::vramWordT'($urandom) & 16'h7fff;
		setMod(16'h0001);
		setAddr(a);
		repeat (20) vramWrite(lspcPkg::vramWordT'($urandom));
		for (int i = 0; i < 20; i++)
		begin
			checkWord(a);
			a = stepRef(a, refMod);
		end
		endTest();

		startTest("fastStrideWrap");
		setMod(16'h0003);
		setAddr(16'h87fe);
		repeat (4) vramWrite(lspcPkg::vramWordT'($urandom));
		a = 16'h87fe;
		repeat (4)
		begin
			checkWord(a);	// 7FE, 001, 004, 007
			a = stepRef(a, refMod);
		end
		endTest();

		startTest("negativeMod");
		setMod(16'hffff);
		setAddr(16'h0001);
		repeat (3) vramWrite(lspcPkg::vramWordT'($urandom));
		checkWord(16'h7fff);	// Wrapped below zero
		checkWord(16'h0000);
		checkWord(16'h0001);
		endTest();

		startTest("readNoStep");
		setAddr(16'h7fff);
		busRead(lspcPkg::regVramRw, refWord(16'h7fff));
		busRead(lspcPkg::regVramRw, refWord(16'h7fff));	// Same word again
		w = ~refWord(16'h7fff);
		vramWrite(w);	// Lands on 7FFF only if the reads left the address alone
		checkWord(16'h7fff);
		endTest();

		startTest("zoneIsolation");
		w = lspcPkg::vramWordT'($urandom);
		setMod(16'h0001);
		setAddr(16'h0010);
		vramWrite(w);
		setAddr(16'h8010);
		vramWrite(~w);
		checkWord(16'h0010);
		checkWord(16'h8010);
		endTest();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
verilog/lspcPkg.sv
verilog/cpuRegDecode.sv
verilog/vramCycle.sv
verilog/cpuReadPort.sv
verilog/lspcVramTop.sv
tests/vramBus_chk.sv
tests/lspcVramTb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module lspcVramTb -Mdir obj_dir -o lspcVramTb

run: compile
	./obj_dir/lspcVramTb | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "Run ended without a result, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
